// File: Bender.yml
package:
  name: rx_scheduler

sources:
  - src/rx_sched_pkg.sv
  - src/rx_sched_ifs.sv
  - src/slot_keeper.sv
  - src/slot_pool.sv
  - src/host_cmd_regs.sv
  - src/port_arbiter.sv
  - src/desc_allocator.sv
  - src/port_tagger.sv
  - src/rx_scheduler.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/rx_scheduler_tb.sv

// File: rx_scheduler.f
src/rx_sched_pkg.sv
src/rx_sched_ifs.sv
src/slot_keeper.sv
src/slot_pool.sv
src/host_cmd_regs.sv
src/port_arbiter.sv
src/desc_allocator.sv
src/port_tagger.sv
src/rx_scheduler.sv
testbench/tb_clk_gen.sv
testbench/rx_scheduler_tb.sv

// File: src/desc_allocator.sv
`timescale 1ns/100ps

module desc_allocator #(
  parameter  CORE_COUNT    = 4,
  parameter  IF_COUNT      = 3,
  parameter  SLOT_COUNT    = 8,
  localparam CORE_ID_WIDTH = $clog2(CORE_COUNT),
  localparam SLOT_WIDTH    = $clog2(SLOT_COUNT + 1)
) (
  input  logic                  clk,
  input  logic                  rst_r,
  input  logic [CORE_COUNT-1:0] income_cores,
  slot_status_if.alloc          slots,
  desc_grant_if.alloc           grants
);
  logic [CORE_COUNT-1:0]    eligible;
  logic                     found;
  logic [CORE_ID_WIDTH-1:0] best_core;
  logic [SLOT_WIDTH-1:0]    best_count;
  logic [IF_COUNT-1:0]      arb_grant;
  logic                     arb_valid;

  assign eligible = income_cores & slots.slot_avail;
  assign found    = |eligible;

  // Strict compare keeps the lowest index on a tie
  always_comb begin
    best_core  = '0;
    best_count = '0;
    for (int i = 0; i < CORE_COUNT; i++) begin
      if (eligible[i] && (slots.slot_count[i] > best_count)) begin
        best_core  = CORE_ID_WIDTH'(i);
        best_count = slots.slot_count[i];
      end
    end
  end

  port_arbiter #(
    .PORTS(IF_COUNT)
  ) port_arb_inst (
    .clk        (clk),
    .rst_r      (rst_r),
    .request    (grants.desc_req),
    .taken      (grants.grant_valid),
    .grant      (arb_grant),
    .grant_valid(arb_valid)
  );

  assign grants.grant_port  = arb_grant;
  assign grants.grant_valid = arb_valid && found;
  assign grants.grant_tag   = {best_core,
                               rx_sched_pkg::tag_width'(slots.slot_head[best_core])};
  assign slots.slot_pop     = grants.grant_valid ? (CORE_COUNT'(1) << best_core) : '0;

endmodule

// File: src/host_cmd_regs.sv
`timescale 1ns/100ps

module host_cmd_regs #(
  parameter  CORE_COUNT    = 4,
  parameter  IF_COUNT      = 3,
  parameter  SLOT_COUNT    = 8,
  localparam CORE_ID_WIDTH = $clog2(CORE_COUNT),
  localparam SLOT_WIDTH    = $clog2(SLOT_COUNT + 1),
  localparam TAG_WIDTH     = CORE_ID_WIDTH + rx_sched_pkg::tag_width
) (
  input  logic                                  clk,
  input  logic                                  rst_r,
  input  logic [31:0]                           host_cmd,
  input  logic [31:0]                           host_cmd_wr_data,
  input  logic                                  host_cmd_valid,
  input  logic [CORE_COUNT-1:0][SLOT_WIDTH-1:0] slot_count,
  input  rx_sched_pkg::port_state_e [IF_COUNT-1:0] port_state,
  input  logic [IF_COUNT-1:0][TAG_WIDTH-1:0]    port_tag,
  output logic [31:0]                           host_cmd_rd_data,
  output logic [CORE_COUNT-1:0]                 enabled_cores,
  output logic [CORE_COUNT-1:0]                 income_cores,
  output logic [CORE_COUNT-1:0]                 slots_flush
);
  rx_sched_pkg::host_reg_e cmd_reg_r;
  logic                    wr_r;
  logic [CORE_COUNT-1:0]   wr_data_r;
  logic [3:0]              index_r;
  logic [31:0]             rd_data_n;
  logic [31:0]             rd_data_r;
  logic [TAG_WIDTH-1:0]    sel_tag;

  always_ff @(posedge clk) begin
    cmd_reg_r <= rx_sched_pkg::host_reg_e'({host_cmd[30], host_cmd[3:0]});
    wr_data_r <= host_cmd_wr_data[CORE_COUNT-1:0];
    index_r   <= host_cmd[7:4];
  end

  // Bit 31 marks a write, bit 29 addresses the scheduler
  always_ff @(posedge clk) begin
    if (rst_r) begin
      wr_r          <= 1'b0;
      enabled_cores <= '0;
      income_cores  <= '0;
      slots_flush   <= '0;
    end else begin
      wr_r        <= host_cmd_valid && host_cmd[31] && host_cmd[29];
      slots_flush <= '0;
      if (wr_r) begin
        case (cmd_reg_r)
          rx_sched_pkg::reg_enabled_cores: begin
            // A core being disabled cannot stay a receiver
            enabled_cores <= wr_data_r;
            income_cores  <= income_cores & wr_data_r;
          end
          rx_sched_pkg::reg_income_cores: income_cores <= wr_data_r & enabled_cores;
          rx_sched_pkg::reg_slot_flush:   slots_flush  <= wr_data_r;
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    sel_tag = (index_r < IF_COUNT) ? port_tag[index_r] : '0;
    case (cmd_reg_r)
      rx_sched_pkg::reg_enabled_cores: rd_data_n = 32'(enabled_cores);
      rx_sched_pkg::reg_income_cores:  rd_data_n = 32'(income_cores);
      rx_sched_pkg::reg_slot_count:
        rd_data_n = (index_r < CORE_COUNT) ? 32'(slot_count[index_r])
                                           : rx_sched_pkg::unmapped_read;
      rx_sched_pkg::reg_port_status:
        rd_data_n = (index_r < IF_COUNT) ?
                    {14'd0, port_state[index_r],
                     8'(sel_tag[TAG_WIDTH-1 -: CORE_ID_WIDTH]),
                     8'(sel_tag[rx_sched_pkg::tag_width-1:0])} :
                    rx_sched_pkg::unmapped_read;
      default: rd_data_n = rx_sched_pkg::unmapped_read;
    endcase
  end

  always_ff @(posedge clk) begin
    rd_data_r        <= rd_data_n;
    host_cmd_rd_data <= rd_data_r;
  end

endmodule

// File: src/port_arbiter.sv
`timescale 1ns/100ps

module port_arbiter #(
  parameter PORTS = 3
) (
  input  logic             clk,
  input  logic             rst_r,
  input  logic [PORTS-1:0] request,
  input  logic             taken,
  output logic [PORTS-1:0] grant,
  output logic             grant_valid
);
  logic [PORTS-1:0] mask;
  logic [PORTS-1:0] masked;
  logic [PORTS-1:0] pick_src;
  logic [PORTS-1:0] next_grant;

  // Ports above the last taken one go first, then wrap around
  assign masked     = request & mask;
  assign pick_src   = (masked != '0) ? masked : request;
  assign next_grant = pick_src & (~pick_src + 1'b1);

  always_ff @(posedge clk) begin
    if (rst_r) begin
      grant       <= '0;
      grant_valid <= 1'b0;
      mask        <= '1;
    end else begin
      grant       <= next_grant;
      grant_valid <= |request;
      if (taken)
        mask <= ~((grant << 1) - 1'b1);
    end
  end

endmodule

// File: src/port_tagger.sv
`timescale 1ns/100ps

module port_tagger #(
  parameter  IF_COUNT   = 3,
  parameter  DATA_WIDTH = 64,
  parameter  CORE_COUNT = 4,
  localparam KEEP_WIDTH = DATA_WIDTH / 8,
  localparam TAG_WIDTH  = $clog2(CORE_COUNT) + rx_sched_pkg::tag_width
) (
  input  logic                                  clk,
  input  logic                                  rst_r,
  input  logic [IF_COUNT*DATA_WIDTH-1:0]        rx_tdata,
  input  logic [IF_COUNT*KEEP_WIDTH-1:0]        rx_tkeep,
  input  logic [IF_COUNT-1:0]                   rx_tvalid,
  input  logic [IF_COUNT-1:0]                   rx_tlast,
  input  logic [IF_COUNT-1:0]                   data_tready,
  output logic [IF_COUNT-1:0]                   rx_tready,
  output logic [IF_COUNT*DATA_WIDTH-1:0]        data_tdata,
  output logic [IF_COUNT*KEEP_WIDTH-1:0]        data_tkeep,
  output logic [IF_COUNT-1:0]                   data_tvalid,
  output logic [IF_COUNT-1:0]                   data_tlast,
  output logic [IF_COUNT*TAG_WIDTH-1:0]         data_tdest,
  output rx_sched_pkg::port_state_e [IF_COUNT-1:0] port_state,
  output logic [IF_COUNT-1:0][TAG_WIDTH-1:0]    port_tag,
  desc_grant_if.tagger                          grants
);
  logic [IF_COUNT-1:0]                active;
  logic [IF_COUNT-1:0]                moving;
  logic [IF_COUNT-1:0]                last_word;
  logic [IF_COUNT-1:0]                granted;
  logic [IF_COUNT-1:0][TAG_WIDTH-1:0] pkt_tag;

  assign granted    = grants.grant_port & {IF_COUNT{grants.grant_valid}};
  assign data_tdata = rx_tdata;
  assign data_tkeep = rx_tkeep;
  assign data_tlast = rx_tlast;

  for (genvar p = 0; p < IF_COUNT; p++) begin : g_port
    assign active[p]      = (port_state[p] != rx_sched_pkg::state_stall);
    assign rx_tready[p]   = data_tready[p] && active[p];
    assign data_tvalid[p] = rx_tvalid[p] && active[p];
    assign moving[p]      = rx_tvalid[p] && rx_tready[p];
    assign last_word[p]   = moving[p] && rx_tlast[p];

    // Ask for the next descriptor as soon as the current one is in use
    assign grants.desc_req[p] = !grants.grant_port[p] &&
                                ((port_state[p] == rx_sched_pkg::state_stall) ||
                                 (port_state[p] == rx_sched_pkg::state_wait) ||
                                 ((port_state[p] == rx_sched_pkg::state_first) && moving[p]));

    assign data_tdest[p*TAG_WIDTH +: TAG_WIDTH] =
      (port_state[p] == rx_sched_pkg::state_first) ? port_tag[p] : pkt_tag[p];
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < IF_COUNT; p++) begin
      if (granted[p])
        port_tag[p] <= grants.grant_tag;
      // Hold the tag for the rest of the packet
      if ((port_state[p] == rx_sched_pkg::state_first) && moving[p])
        pkt_tag[p] <= port_tag[p];
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < IF_COUNT; p++) begin
      if (rst_r) begin
        port_state[p] <= rx_sched_pkg::state_stall;
      end else begin
        case (port_state[p])
          rx_sched_pkg::state_stall:
            if (granted[p])
              port_state[p] <= rx_sched_pkg::state_first;
          rx_sched_pkg::state_first:
            if (last_word[p])
              port_state[p] <= rx_sched_pkg::state_stall;
            else if (moving[p])
              port_state[p] <= rx_sched_pkg::state_wait;
          rx_sched_pkg::state_wait:
            if (granted[p] && last_word[p])
              port_state[p] <= rx_sched_pkg::state_first;
            else if (granted[p])
              port_state[p] <= rx_sched_pkg::state_mid;
            else if (last_word[p])
              port_state[p] <= rx_sched_pkg::state_stall;
          rx_sched_pkg::state_mid:
            if (last_word[p])
              port_state[p] <= rx_sched_pkg::state_first;
        endcase
      end
    end
  end

endmodule

// File: src/rx_sched_ifs.sv
`timescale 1ns/100ps

interface slot_status_if #(
  parameter CORE_COUNT = 4,
  parameter SLOT_COUNT = 8
);
  localparam SLOT_WIDTH = $clog2(SLOT_COUNT + 1);

  logic [CORE_COUNT-1:0][SLOT_WIDTH-1:0] slot_count;
  logic [CORE_COUNT-1:0][SLOT_WIDTH-1:0] slot_head;
  logic [CORE_COUNT-1:0]                 slot_avail;
  logic [CORE_COUNT-1:0]                 slot_pop;

  modport pool (output slot_count, slot_head, slot_avail, input slot_pop);
  modport alloc (input slot_count, slot_head, slot_avail, output slot_pop);
endinterface

interface desc_grant_if #(
  parameter IF_COUNT   = 3,
  parameter CORE_COUNT = 4
);
  localparam TAG_WIDTH = $clog2(CORE_COUNT) + rx_sched_pkg::tag_width;

  logic [IF_COUNT-1:0]  desc_req;
  logic [IF_COUNT-1:0]  grant_port;
  logic                 grant_valid;
  logic [TAG_WIDTH-1:0] grant_tag;

  modport tagger (output desc_req, input grant_port, grant_valid, grant_tag);
  modport alloc (input desc_req, output grant_port, grant_valid, grant_tag);
endinterface

// File: src/rx_sched_pkg.sv
package rx_sched_pkg;

  // Slot field inside a descriptor tag
  localparam int tag_width = 5;

  // Control word layout
  localparam int msg_type_width = 4;
  localparam int slot_field_lsb = 16;

  localparam logic [msg_type_width-1:0] msg_enq_slot   = 4'd0;
  localparam logic [msg_type_width-1:0] msg_init_slots = 4'd3;

  localparam logic [31:0] unmapped_read = 32'hFEFEFEFE;

  typedef enum logic [1:0] {
    state_stall,
    state_first,
    state_wait,
    state_mid
  } port_state_e;

  // Interface-space bit on top of the 4-bit register field
  typedef enum logic [4:0] {
    reg_enabled_cores = 5'h00,
    reg_income_cores  = 5'h01,
    reg_slot_flush    = 5'h02,
    reg_slot_count    = 5'h03,
    reg_port_status   = 5'h10
  } host_reg_e;

endpackage

// File: src/rx_scheduler.sv
`timescale 1ns/100ps

module rx_scheduler #(
  parameter  IF_COUNT      = 3,
  parameter  CORE_COUNT    = 4,
  parameter  SLOT_COUNT    = 8,
  parameter  DATA_WIDTH    = 64,
  parameter  CTRL_WIDTH    = 36,
  localparam CORE_ID_WIDTH = $clog2(CORE_COUNT),
  localparam KEEP_WIDTH    = DATA_WIDTH / 8,
  localparam TAG_WIDTH     = CORE_ID_WIDTH + rx_sched_pkg::tag_width
) (
  input  logic                           clk,
  input  logic                           rst_r,

  input  logic [IF_COUNT*DATA_WIDTH-1:0] rx_tdata,
  input  logic [IF_COUNT*KEEP_WIDTH-1:0] rx_tkeep,
  input  logic [IF_COUNT-1:0]            rx_tvalid,
  output logic [IF_COUNT-1:0]            rx_tready,
  input  logic [IF_COUNT-1:0]            rx_tlast,

  output logic [IF_COUNT*DATA_WIDTH-1:0] data_tdata,
  output logic [IF_COUNT*KEEP_WIDTH-1:0] data_tkeep,
  output logic [IF_COUNT-1:0]            data_tvalid,
  input  logic [IF_COUNT-1:0]            data_tready,
  output logic [IF_COUNT-1:0]            data_tlast,
  output logic [IF_COUNT*TAG_WIDTH-1:0]  data_tdest,

  input  logic [CTRL_WIDTH-1:0]          ctrl_tdata,
  input  logic                           ctrl_tvalid,
  input  logic [CORE_ID_WIDTH-1:0]       ctrl_tuser,

  input  logic [31:0]                    host_cmd,
  input  logic [31:0]                    host_cmd_wr_data,
  input  logic                           host_cmd_valid,
  output logic [31:0]                    host_cmd_rd_data
);
  rx_sched_pkg::port_state_e [IF_COUNT-1:0] port_state;
  logic [IF_COUNT-1:0][TAG_WIDTH-1:0]       port_tag;
  logic [CORE_COUNT-1:0]                    income_cores;
  logic [CORE_COUNT-1:0]                    slots_flush;

  slot_status_if #(.CORE_COUNT(CORE_COUNT), .SLOT_COUNT(SLOT_COUNT)) slot_status ();
  desc_grant_if #(.IF_COUNT(IF_COUNT), .CORE_COUNT(CORE_COUNT)) desc_grant ();

  slot_pool #(
    .CORE_COUNT(CORE_COUNT),
    .SLOT_COUNT(SLOT_COUNT),
    .CTRL_WIDTH(CTRL_WIDTH)
  ) slot_pool_inst (
    .clk        (clk),
    .rst_r      (rst_r),
    .ctrl_tdata (ctrl_tdata),
    .ctrl_tvalid(ctrl_tvalid),
    .ctrl_tuser (ctrl_tuser),
    .slots_flush(slots_flush),
    .slots      (slot_status.pool)
  );

  host_cmd_regs #(
    .CORE_COUNT(CORE_COUNT),
    .IF_COUNT  (IF_COUNT),
    .SLOT_COUNT(SLOT_COUNT)
  ) host_cmd_regs_inst (
    .clk             (clk),
    .rst_r           (rst_r),
    .host_cmd        (host_cmd),
    .host_cmd_wr_data(host_cmd_wr_data),
    .host_cmd_valid  (host_cmd_valid),
    .slot_count      (slot_status.slot_count),
    .port_state      (port_state),
    .port_tag        (port_tag),
    .host_cmd_rd_data(host_cmd_rd_data),
    .enabled_cores   (),
    .income_cores    (income_cores),
    .slots_flush     (slots_flush)
  );

  desc_allocator #(
    .CORE_COUNT(CORE_COUNT),
    .IF_COUNT  (IF_COUNT),
    .SLOT_COUNT(SLOT_COUNT)
  ) desc_allocator_inst (
    .clk         (clk),
    .rst_r       (rst_r),
    .income_cores(income_cores),
    .slots       (slot_status.alloc),
    .grants      (desc_grant.alloc)
  );

  port_tagger #(
    .IF_COUNT  (IF_COUNT),
    .DATA_WIDTH(DATA_WIDTH),
    .CORE_COUNT(CORE_COUNT)
  ) port_tagger_inst (
    .clk        (clk),
    .rst_r      (rst_r),
    .rx_tdata   (rx_tdata),
    .rx_tkeep   (rx_tkeep),
    .rx_tvalid  (rx_tvalid),
    .rx_tlast   (rx_tlast),
    .data_tready(data_tready),
    .rx_tready  (rx_tready),
    .data_tdata (data_tdata),
    .data_tkeep (data_tkeep),
    .data_tvalid(data_tvalid),
    .data_tlast (data_tlast),
    .data_tdest (data_tdest),
    .port_state (port_state),
    .port_tag   (port_tag),
    .grants     (desc_grant.tagger)
  );

endmodule

// File: src/slot_keeper.sv
`timescale 1ns/100ps

module slot_keeper #(
  parameter  SLOT_COUNT = 8,
  localparam SLOT_WIDTH = $clog2(SLOT_COUNT + 1)
) (
  input  logic                  clk,
  input  logic                  rst_r,
  input  logic                  flush,
  input  logic                  init_valid,
  input  logic [SLOT_WIDTH-1:0] init_slots,
  input  logic                  enq_valid,
  input  logic [SLOT_WIDTH-1:0] enq_slot,
  input  logic                  pop,
  output logic [SLOT_WIDTH-1:0] head,
  output logic                  avail,
  output logic [SLOT_WIDTH-1:0] count
);
  localparam PTR_WIDTH = $clog2(SLOT_COUNT);

  logic [SLOT_WIDTH-1:0] mem [SLOT_COUNT];
  logic [PTR_WIDTH-1:0]  rd_ptr;
  logic [PTR_WIDTH-1:0]  wr_ptr;
  logic [SLOT_WIDTH-1:0] init_count;
  logic [PTR_WIDTH-1:0]  init_ptr;
  logic                  do_enq;
  logic                  do_pop;

  function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
    return (ptr == PTR_WIDTH'(SLOT_COUNT - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign avail  = (count != '0);
  assign head   = mem[rd_ptr];
  assign do_enq = enq_valid && (count != SLOT_WIDTH'(SLOT_COUNT));
  assign do_pop = pop && avail;

  // More slots than the list holds are clipped
  assign init_count = (init_slots > SLOT_WIDTH'(SLOT_COUNT)) ? SLOT_WIDTH'(SLOT_COUNT)
                                                             : init_slots;
  assign init_ptr   = (init_count == SLOT_WIDTH'(SLOT_COUNT)) ? '0
                                                              : init_count[PTR_WIDTH-1:0];

  always_ff @(posedge clk) begin
    if (rst_r || flush) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else if (init_valid) begin
      rd_ptr <= '0;
      wr_ptr <= init_ptr;
      count  <= init_count;
    end else begin
      if (do_enq)
        wr_ptr <= next_ptr(wr_ptr);
      if (do_pop)
        rd_ptr <= next_ptr(rd_ptr);
      if (do_enq && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_enq)
        count <= count - 1'b1;
    end
  end

  // Slot numbers start from 1
  always_ff @(posedge clk) begin
    if (init_valid) begin
      for (int i = 0; i < SLOT_COUNT; i++)
        mem[i] <= SLOT_WIDTH'(i + 1);
    end else if (do_enq) begin
      mem[wr_ptr] <= enq_slot;
    end
  end

endmodule

// File: src/slot_pool.sv
`timescale 1ns/100ps

module slot_pool #(
  parameter  CORE_COUNT    = 4,
  parameter  SLOT_COUNT    = 8,
  parameter  CTRL_WIDTH    = 36,
  localparam CORE_ID_WIDTH = $clog2(CORE_COUNT),
  localparam SLOT_WIDTH    = $clog2(SLOT_COUNT + 1)
) (
  input  logic                     clk,
  input  logic                     rst_r,
  input  logic [CTRL_WIDTH-1:0]    ctrl_tdata,
  input  logic                     ctrl_tvalid,
  input  logic [CORE_ID_WIDTH-1:0] ctrl_tuser,
  input  logic [CORE_COUNT-1:0]    slots_flush,
  slot_status_if.pool              slots
);
  logic                                    msg_valid_r;
  logic [rx_sched_pkg::msg_type_width-1:0] msg_type_r;
  logic [CORE_ID_WIDTH-1:0]                msg_core_r;
  logic [SLOT_WIDTH-1:0]                   msg_slot_r;
  logic [SLOT_WIDTH-1:0]                   slot_rr;
  logic [CORE_COUNT-1:0]                   init_v;
  logic [CORE_COUNT-1:0]                   enq_v;

  always_ff @(posedge clk) begin
    msg_type_r <= ctrl_tdata[CTRL_WIDTH-1 -: rx_sched_pkg::msg_type_width];
    msg_core_r <= ctrl_tuser;
    msg_slot_r <= ctrl_tdata[rx_sched_pkg::slot_field_lsb +: SLOT_WIDTH];
    slot_rr    <= msg_slot_r;
  end

  // Per-core strobes, other message types fall through
  always_ff @(posedge clk) begin
    if (rst_r) begin
      msg_valid_r <= 1'b0;
      init_v      <= '0;
      enq_v       <= '0;
    end else begin
      msg_valid_r <= ctrl_tvalid;
      for (int i = 0; i < CORE_COUNT; i++) begin
        init_v[i] <= msg_valid_r && (msg_type_r == rx_sched_pkg::msg_init_slots) &&
                     (msg_core_r == CORE_ID_WIDTH'(i));
        enq_v[i]  <= msg_valid_r && (msg_type_r == rx_sched_pkg::msg_enq_slot) &&
                     (msg_core_r == CORE_ID_WIDTH'(i));
      end
    end
  end

  for (genvar i = 0; i < CORE_COUNT; i++) begin : g_keeper
    slot_keeper #(
      .SLOT_COUNT(SLOT_COUNT)
    ) keeper_inst (
      .clk       (clk),
      .rst_r     (rst_r),
      .flush     (slots_flush[i]),
      .init_valid(init_v[i]),
      .init_slots(slot_rr),
      .enq_valid (enq_v[i]),
      .enq_slot  (slot_rr),
      .pop       (slots.slot_pop[i]),
      .head      (slots.slot_head[i]),
      .avail     (slots.slot_avail[i]),
      .count     (slots.slot_count[i])
    );
  end

endmodule

// File: testbench/rx_scheduler_tb.sv
`timescale 1ns/100ps

module rx_scheduler_tb;
  localparam IFS = 3;
  localparam CORES = 4;
  localparam DW = 64;
  localparam TW = 7;
  localparam MAX_CYCLES = 4000;
  // Unmapped code parked on host_cmd between commands
  localparam logic [31:0] IDLE_CMD = 32'h0000_000F;

  logic              clk;
  logic              rst_r;
  logic [IFS*DW-1:0] rx_tdata;
  logic [IFS*8-1:0]  rx_tkeep;
  logic [IFS-1:0]    rx_tvalid;
  logic [IFS-1:0]    rx_tready;
  logic [IFS-1:0]    rx_tlast;
  logic [IFS*DW-1:0] data_tdata;
  logic [IFS*8-1:0]  data_tkeep;
  logic [IFS-1:0]    data_tvalid;
  logic [IFS-1:0]    data_tready;
  logic [IFS-1:0]    data_tlast;
  logic [IFS*TW-1:0] data_tdest;
  logic [35:0]       ctrl_tdata;
  logic              ctrl_tvalid;
  logic [1:0]        ctrl_tuser;
  logic [31:0]       host_cmd;
  logic [31:0]       host_cmd_wr_data;
  logic              host_cmd_valid;
  logic [31:0]       host_cmd_rd_data;

  int errors = 0;
  int checks = 0;
  int cycles = 0;
  bit bp_en = 0;

  // Reference model of the slot lists, the enables and the outstanding tags
  int              slot_model [CORES][$];
  logic [CORES-1:0] model_en;
  logic [CORES-1:0] model_inc;
  logic [CORES-1:0] flush_pend;
  logic [TW-1:0]   exp_tag [IFS][$];
  logic [63:0]     word_q [IFS][$];
  // Last flag above the keep bits of every sent word
  logic [8:0]      side_q [IFS][$];
  logic [TW-1:0]   cur_tag [IFS];
  bit              in_pkt [IFS];
  bit              outstanding [1<<TW];
  logic            c0_v, c1_v, h0_v;
  logic [3:0]      c0_type, c1_type, c0_slot, c1_slot;
  logic [1:0]      c0_core, c1_core;
  logic [4:0]      h0_reg;
  logic [3:0]      h0_dat;

  wire           grant_valid = rx_scheduler_inst.desc_grant.grant_valid;
  wire [IFS-1:0] grant_port  = rx_scheduler_inst.desc_grant.grant_port;
  wire [TW-1:0]  grant_tag   = rx_scheduler_inst.desc_grant.grant_tag;

  tb_clk_gen #(.PERIOD(40), .RESET_CYCLES(2)) clk_gen_inst (.clk(clk), .rst_r(rst_r));

  rx_scheduler #(
    .IF_COUNT(IFS), .CORE_COUNT(CORES), .SLOT_COUNT(8), .DATA_WIDTH(DW), .CTRL_WIDTH(36)
  ) rx_scheduler_inst (.*);

  task automatic check_equal(string name, logic [63:0] got, logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic fail_check(string msg);
    errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  task automatic check_ports();
    logic          has_desc;
    logic [63:0]   word;
    logic [8:0]    side;
    for (int p = 0; p < IFS; p++) begin
      has_desc = in_pkt[p] || (exp_tag[p].size() != 0);
      check_equal($sformatf("data_tvalid[%0d]", p), data_tvalid[p], rx_tvalid[p] && has_desc);
      check_equal($sformatf("rx_tready[%0d]", p), rx_tready[p], data_tready[p] && has_desc);
      if (data_tvalid[p] && data_tready[p]) begin
        if (!in_pkt[p] && exp_tag[p].size() == 0) begin
          fail_check($sformatf("word left port %0d without a descriptor", p));
          continue;
        end
        if (!in_pkt[p]) begin
          cur_tag[p] = exp_tag[p].pop_front();
          in_pkt[p] = 1;
        end
        check_equal($sformatf("data_tdest[%0d]", p), data_tdest[p*TW +: TW], cur_tag[p]);
        if (word_q[p].size() == 0) begin
          fail_check($sformatf("port %0d passed a word that was never sent", p));
          continue;
        end
        word = word_q[p].pop_front();
        side = side_q[p].pop_front();
        check_equal($sformatf("data_tdata[%0d]", p), data_tdata[p*DW +: DW], word);
        check_equal($sformatf("data_tkeep[%0d]", p), data_tkeep[p*8 +: 8], side[7:0]);
        check_equal($sformatf("data_tlast[%0d]", p), data_tlast[p], side[8]);
        if (side[8]) begin
          in_pkt[p] = 0;
          outstanding[cur_tag[p]] = 0;
        end
      end
    end
  endtask

  // Pick the largest list among receiving cores and the lowest index on a tie
  task automatic track_grant();
    int            best;
    int            best_n;
    logic [TW-1:0] tag;
    best = -1;
    best_n = 0;
    if (!grant_valid)
      return;
    for (int c = 0; c < CORES; c++) begin
      if (model_inc[c] && slot_model[c].size() > best_n) begin
        best = c;
        best_n = slot_model[c].size();
      end
    end
    if (best < 0) begin
      fail_check("descriptor granted while no core had a free slot");
      return;
    end
    if (!$onehot(grant_port)) begin
      fail_check("descriptor granted to no port or to several ports");
      return;
    end
    tag = {best[1:0], 5'(slot_model[best][0])};
    check_equal("grant_tag", grant_tag, tag);
    if (outstanding[tag])
      fail_check($sformatf("tag %h handed out while still in use", tag));
    outstanding[tag] = 1;
    void'(slot_model[best].pop_front());
    for (int p = 0; p < IFS; p++)
      if (grant_port[p])
        exp_tag[p].push_back(tag);
  endtask

  // Control messages and flushes reach the lists two edges after sampling
  task automatic apply_pipes();
    if (c1_v && c1_type == rx_sched_pkg::msg_init_slots) begin
      slot_model[c1_core].delete();
      for (int i = 1; i <= c1_slot && i <= 8; i++)
        slot_model[c1_core].push_back(i);
    end else if (c1_v && c1_type == rx_sched_pkg::msg_enq_slot) begin
      if (slot_model[c1_core].size() < 8)
        slot_model[c1_core].push_back(c1_slot);
    end
    for (int c = 0; c < CORES; c++)
      if (flush_pend[c])
        slot_model[c].delete();
    flush_pend = '0;
    if (h0_v) begin
      case (h0_reg)
        5'h00: begin
          model_en = h0_dat;
          model_inc = model_inc & h0_dat;
        end
        5'h01: model_inc = h0_dat & model_en;
        5'h02: flush_pend = h0_dat;
        default: ;
      endcase
    end
    {c1_v, c1_type, c1_core, c1_slot} = {c0_v, c0_type, c0_core, c0_slot};
    {c0_v, c0_type, c0_core, c0_slot} = {ctrl_tvalid, ctrl_tdata[35:32], ctrl_tuser,
                                         ctrl_tdata[19:16]};
    h0_v = host_cmd_valid && host_cmd[31] && host_cmd[29];
    h0_reg = {host_cmd[30], host_cmd[3:0]};
    h0_dat = host_cmd_wr_data[3:0];
  endtask

  always @(posedge clk) begin
    if (rst_r) begin
      model_en = '0;
      model_inc = '0;
      flush_pend = '0;
      {c0_v, c1_v, h0_v} = '0;
    end else begin
      check_ports();
      track_grant();
      apply_pipes();
    end
  end

  assert property (@(posedge clk) disable iff (rst_r) (rx_tready & ~data_tready) == '0)
    else begin
      errors++;
      $display("Error at %0t: rx_tready high while data_tready is low", $time);
    end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, checks: %0d, errors: %0d", cycles, checks, errors);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  task automatic host_write(logic [4:0] code, logic [31:0] data);
    @(negedge clk);
    host_cmd = {1'b1, code[4], 1'b1, 25'd0, code[3:0]};
    host_cmd_wr_data = data;
    host_cmd_valid = 1'b1;
    @(negedge clk);
    host_cmd_valid = 1'b0;
    host_cmd = IDLE_CMD;
    repeat (2) @(negedge clk);
  endtask

  // The code is presented for one cycle only, so the value must show on the third edge
  task automatic check_read(string name, logic [4:0] code, logic [3:0] idx, logic [31:0] exp);
    @(negedge clk);
    host_cmd = {1'b0, code[4], 22'd0, idx, code[3:0]};
    @(negedge clk);
    host_cmd = IDLE_CMD;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_equal(name, host_cmd_rd_data, exp);
  endtask

  task automatic send_ctrl(logic [3:0] kind, logic [1:0] core, logic [3:0] slot);
    @(negedge clk);
    ctrl_tdata = {kind, 12'd0, slot, 16'd0};
    ctrl_tuser = core;
    ctrl_tvalid = 1'b1;
    @(negedge clk);
    ctrl_tvalid = 1'b0;
  endtask

  task automatic check_counts();
    for (int c = 0; c < CORES; c++)
      check_read($sformatf("slot_count[%0d]", c), 5'h03, c, slot_model[c].size());
  endtask

  task automatic send_packet(int p, int n);
    logic [63:0] word;
    logic [7:0]  keep;
    int          gap;
    for (int w = 0; w < n; w++) begin
      word = {$urandom, $urandom};
      keep = 8'($urandom);
      gap = $urandom % 3;
      repeat (gap) @(negedge clk);
      rx_tdata[p*DW +: DW] = word;
      rx_tkeep[p*8 +: 8] = keep;
      rx_tlast[p] = (w == n - 1);
      rx_tvalid[p] = 1'b1;
      word_q[p].push_back(word);
      side_q[p].push_back({rx_tlast[p], keep});
      do @(posedge clk); while (!rx_tready[p]);
      @(negedge clk);
      rx_tvalid[p] = 1'b0;
      rx_tlast[p] = 1'b0;
    end
  endtask

  initial begin
    void'($urandom(32'haecd_eaab));
    rx_tdata = '0;
    rx_tkeep = '1;
    rx_tvalid = '0;
    rx_tlast = '0;
    data_tready = '1;
    ctrl_tdata = '0;
    ctrl_tvalid = 1'b0;
    ctrl_tuser = '0;
    host_cmd = IDLE_CMD;
    host_cmd_wr_data = '0;
    host_cmd_valid = 1'b0;
    @(negedge clk);
    while (rst_r) @(negedge clk);

    check_read("enabled_cores", 5'h00, 0, 0);
    check_read("unmapped", 5'h05, 0, 32'hFEFEFEFE);

    host_write(5'h00, 32'h3);
    host_write(5'h01, 32'hF);
    check_read("income_cores", 5'h01, 0, 32'h3);
    host_write(5'h00, 32'h1);
    check_read("income_cores", 5'h01, 0, 32'h1);
    check_read("enabled_cores", 5'h00, 0, 32'h1);
    host_write(5'h01, 32'h0);
    host_write(5'h00, 32'hF);

    // Unknown message types 5 and 9 must leave the lists alone
    send_ctrl(4'd3, 0, 3);
    send_ctrl(4'd3, 1, 5);
    send_ctrl(4'd3, 2, 2);
    send_ctrl(4'd3, 3, 5);
    send_ctrl(4'd0, 2, 12);
    send_ctrl(4'd0, 0, 7);
    send_ctrl(4'd5, 1, 9);
    send_ctrl(4'd9, 3, 1);
    repeat (4) @(negedge clk);
    check_counts();

    host_write(5'h01, 32'hF);
    repeat (6) @(negedge clk);
    repeat (4) send_packet(0, 1 + $urandom % 4);

    fork
      repeat (3) send_packet(0, 1 + $urandom % 4);
      repeat (3) send_packet(1, 1 + $urandom % 4);
      repeat (3) send_packet(2, 1 + $urandom % 4);
      begin
        repeat (8) @(negedge clk);
        send_ctrl(4'd0, 3, 10);
        send_ctrl(4'd0, 0, 11);
      end
    join

    bp_en = 1;
    fork
      begin
        repeat (2) send_packet(1, 5);
        bp_en = 0;
      end
      while (bp_en) begin
        @(negedge clk);
        data_tready = IFS'($urandom);
      end
    join
    data_tready = '1;
    repeat (10) @(negedge clk);
    check_counts();

    host_write(5'h02, 32'hF);
    repeat (4) @(negedge clk);
    check_counts();
    send_packet(2, 2);
    fork
      send_packet(2, 2);
      begin
        repeat (6) @(negedge clk);
        send_ctrl(4'd3, 1, 2);
      end
    join
    repeat (10) @(negedge clk);
    check_counts();

    repeat (5) @(negedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: testbench/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter PERIOD       = 40,
  parameter RESET_CYCLES = 2
) (
  output logic clk,
  output logic rst_r
);
  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst_r = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_r <= 1'b0;
  end

endmodule
